//--- sim.f
computer_pkg.sv
bus_ctrl.sv
input_capture.sv
hex_display.sv
de1_soc_computer.sv
computer_asserts.sv
tb_de1_soc_computer.sv

//--- tb_de1_soc_computer.sv
// Testbench for the DE1-SoC peripheral subsystem
// Host bus driver, register and segment reference model, read compare and watchdog
module tb_de1_soc_computer;
	timeunit 1ns;
	timeprecision 100ps;
	import computer_pkg::*;

	localparam int num_sw      = 10;
	localparam int num_key     = 4;
	localparam int num_led     = 10;
	localparam int clk_ns      = 4;
	localparam int rst_cycles  = 16;
	localparam int settle      = 4;
	// Budget of 50 accesses at 20 cycles each
	localparam int max_xfers   = 50;
	localparam int xfer_cycles = 20;
	localparam int watchdog_ns = (max_xfers * xfer_cycles + rst_cycles) * clk_ns;

	logic                 clock_50;
	logic                 arst_n;
	logic                 req;
	logic                 we;
	logic [addr_w-1:0]    addr;
	logic [data_w-1:0]    wdata;
	logic                 ack;
	logic [data_w-1:0]    rdata;
	logic [num_sw-1:0]    sw;
	logic [num_key-1:0]   key;
	logic [num_led-1:0]   ledr;
	logic [seg_w-1:0]     hex0;
	logic [seg_w-1:0]     hex1;
	logic [seg_w-1:0]     hex2;
	logic [seg_w-1:0]     hex3;
	logic [seg_w-1:0]     hex4;
	logic [seg_w-1:0]     hex5;

	//////////////////////////////////////////////////////////////////////
	// Reference model state
	//////////////////////////////////////////////////////////////////////

	logic [num_led-1:0]   led_m;
	logic [num_sw-1:0]    sw_m;
	// Pressed keys, active high
	logic [num_key-1:0]   key_m;
	logic [num_key-1:0]   edge_m;
	logic [data_w-1:0]    lo_m;
	logic [data_w/2-1:0]  hi_m;
	logic                 mode_m;

	int seed      = 84696;
	int err_cnt   = 0;
	int check_cnt = 0;
	int test_errs = 0;

	// Completed reads waiting for the compare process
	logic [addr_w-1:0]    addr_q[$];
	logic [data_w-1:0]    act_q[$];
	logic [data_w-1:0]    exp_q[$];

	de1_soc_computer #(
		.num_sw  (num_sw),
		.num_key (num_key),
		.num_led (num_led)
	) dut0 (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.req      (req),
		.we       (we),
		.addr     (addr),
		.wdata    (wdata),
		.ack      (ack),
		.rdata    (rdata),
		.sw       (sw),
		.key      (key),
		.ledr     (ledr),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3),
		.hex4     (hex4),
		.hex5     (hex5)
	);

	initial begin : clock_gen
		clock_50 = 1'b0;
		forever #(clk_ns / 2) clock_50 = ~clock_50;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference functions
	//////////////////////////////////////////////////////////////////////

	// Segments a..g in bits 0..6 for each hex digit
	function automatic logic [6:0] font_of(input logic [3:0] d);
		case (d)
			4'h0: return 7'h3f;
			4'h1: return 7'h06;
			4'h2: return 7'h5b;
			4'h3: return 7'h4f;
			4'h4: return 7'h66;
			4'h5: return 7'h6d;
			4'h6: return 7'h7d;
			4'h7: return 7'h07;
			4'h8: return 7'h7f;
			4'h9: return 7'h6f;
			4'ha: return 7'h77;
			4'hb: return 7'h7c;
			4'hc: return 7'h39;
			4'hd: return 7'h5e;
			4'he: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	// Expected active-low pin pattern for one display byte
	function automatic logic [6:0] pin_ref(input logic [7:0] b, input logic dig);
		if (!dig) begin
			return ~b[6:0];
		end
		if (b[7]) begin
			return 7'h7f;
		end
		return ~font_of(b[3:0]);
	endfunction

	// Expected read data for each register address
	function automatic logic [data_w-1:0] ref_read(input logic [addr_w-1:0] a);
		logic [data_w-1:0] r;
		r = '0;
		case (a)
			reg_led:      r[num_led-1:0]  = led_m;
			reg_sw:       r[num_sw-1:0]   = sw_m;
			reg_key:      r[num_key-1:0]  = key_m;
			reg_edge:     r[num_key-1:0]  = edge_m;
			reg_hex3_0:   r               = lo_m;
			reg_hex5_4:   r[data_w/2-1:0] = hi_m;
			reg_hex_mode: r[0]            = mode_m;
			default:      r               = '0;
		endcase
		return r;
	endfunction

	// Model side effects of a completed write
	function automatic void model_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
		case (a)
			reg_led:      led_m  = d[num_led-1:0];
			reg_edge:     edge_m = edge_m & ~d[num_key-1:0];
			reg_hex3_0:   lo_m   = d;
			reg_hex5_4:   hi_m   = d[data_w/2-1:0];
			reg_hex_mode: mode_m = d[0];
			default:      ;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and bus driver
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [data_w-1:0] act,
		input logic [data_w-1:0] exp);
		check_cnt++;
		if (act !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
			err_cnt++;
		end
	endtask

	// Compare all six displays against the model
	task automatic check_pins();
		logic [5:0][6:0] pins;
		logic [7:0]      b;
		pins = {hex5, hex4, hex3, hex2, hex1, hex0};
		for (int i = 0; i < 6; i++) begin
			b = (i < 4) ? lo_m[8*i +: 8] : hi_m[8*(i-4) +: 8];
			compare_value($sformatf("hex%0d", i), pins[i], pin_ref(b, mode_m));
		end
	endtask

	// One four-phase access, inputs change 1 ns after the edge
	task automatic bus_xfer(input logic wr, input logic [addr_w-1:0] a,
		input logic [data_w-1:0] d);
		int n;
		@(posedge clock_50);
		#1;
		req   = 1'b1;
		we    = wr;
		addr  = a;
		wdata = d;
		n     = 0;
		do begin
			@(posedge clock_50);
			#1;
			n++;
		end while (!ack && n < xfer_cycles);
		if (!ack) begin
			$display("Bus timeout at %0t ns: no ack for address %0d", $time, a);
			err_cnt++;
		end else if (wr) begin
			model_write(a, d);
		end else begin
			addr_q.push_back(a);
			act_q.push_back(rdata);
			exp_q.push_back(ref_read(a));
		end
		req = 1'b0;
		n   = 0;
		while (ack && n < xfer_cycles) begin
			@(posedge clock_50);
			#1;
			n++;
		end
		if (ack) begin
			$display("Bus timeout at %0t ns: ack stayed high after req dropped", $time);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		wait (exp_q.size() == 0);
		$display("Test %s finished with %0d errors", name, err_cnt - test_errs);
		test_errs = err_cnt;
	endtask

	// Read results checked in order of completion
	initial begin : compare_reads
		logic [addr_w-1:0] a;
		logic [data_w-1:0] act;
		logic [data_w-1:0] exp;
		forever begin
			wait (exp_q.size() != 0);
			a   = addr_q.pop_front();
			act = act_q.pop_front();
			exp = exp_q.pop_front();
			compare_value($sformatf("rdata addr %0d", a), act, exp);
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Watchdog timeout: tests did not finish within %0d ns", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		logic [data_w-1:0]  d;
		logic [num_key-1:0] press;
		int                 total;
		req    = 1'b0;
		we     = 1'b0;
		addr   = '0;
		wdata  = '0;
		sw     = '0;
		// Keys released, pins idle high
		key    = '1;
		arst_n = 1'b0;
		led_m  = '0;
		sw_m   = '0;
		key_m  = '0;
		edge_m = '0;
		lo_m   = '0;
		hi_m   = '0;
		mode_m = 1'b0;
		repeat (rst_cycles) @(posedge clock_50);
		#1;
		arst_n = 1'b1;

		// Reset values
		compare_value("ledr", ledr, '0);
		check_pins();
		bus_xfer(1'b0, reg_led, '0);
		bus_xfer(1'b0, reg_hex3_0, '0);
		bus_xfer(1'b0, reg_hex5_4, '0);
		bus_xfer(1'b0, reg_hex_mode, '0);
		end_test("reset_state");

		// Random writes, read back, upper HEX5_4 half dropped
		repeat (3) begin
			d = $random(seed);
			bus_xfer(1'b1, reg_led, d);
			d = $random(seed);
			bus_xfer(1'b1, reg_hex3_0, d);
			d = $random(seed);
			bus_xfer(1'b1, reg_hex5_4, d);
			bus_xfer(1'b0, reg_led, '0);
			bus_xfer(1'b0, reg_hex3_0, '0);
			bus_xfer(1'b0, reg_hex5_4, '0);
		end
		compare_value("ledr", ledr, led_m);
		// Unmapped address
		bus_xfer(1'b1, 3'd7, 32'hffff_ffff);
		bus_xfer(1'b0, 3'd7, '0);
		end_test("read_back");

		// Raw segment bytes
		d = $random(seed);
		bus_xfer(1'b1, reg_hex3_0, d);
		d = $random(seed);
		bus_xfer(1'b1, reg_hex5_4, d);
		check_pins();
		end_test("raw_mode");

		// Digits, HEX2 and HEX5 blanked
		bus_xfer(1'b1, reg_hex_mode, 32'h1);
		d = $random(seed);
		d[7]  = 1'b0;
		d[15] = 1'b0;
		d[23] = 1'b1;
		d[31] = 1'b0;
		bus_xfer(1'b1, reg_hex3_0, d);
		d = $random(seed);
		d[7]  = 1'b0;
		d[15] = 1'b1;
		bus_xfer(1'b1, reg_hex5_4, d);
		bus_xfer(1'b0, reg_hex_mode, '0);
		check_pins();
		end_test("digit_mode");

		// Switch levels after synchronizer settle
		@(posedge clock_50);
		#1;
		sw   = $random(seed);
		sw_m = sw;
		repeat (settle) @(posedge clock_50);
		bus_xfer(1'b0, reg_sw, '0);

		// Press a random nonzero key set
		press = $random(seed);
		if (press == '0) begin
			press = 4'b0101;
		end
		@(posedge clock_50);
		#1;
		key    = ~press;
		key_m  = press;
		edge_m = press;
		repeat (settle) @(posedge clock_50);
		bus_xfer(1'b0, reg_key, '0);
		bus_xfer(1'b0, reg_edge, '0);

		// Release, edge bits stay sticky
		@(posedge clock_50);
		#1;
		key   = '1;
		key_m = '0;
		repeat (settle) @(posedge clock_50);
		bus_xfer(1'b0, reg_key, '0);
		bus_xfer(1'b0, reg_edge, '0);
		bus_xfer(1'b1, reg_edge, 32'hf);
		bus_xfer(1'b0, reg_edge, '0);
		end_test("switches_keys");

		wait (exp_q.size() == 0);
		total = err_cnt + dut0.u_bus_ctrl.u_asserts.fail_cnt;
		$display("Checks %0d, mismatches %0d, assertion failures %0d", check_cnt, err_cnt,
			dut0.u_bus_ctrl.u_asserts.fail_cnt);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- computer_asserts.sv
// Bus handshake checks for the peripheral subsystem
// Bound into the bus slave, covers reset state, ack timing and write strobes
module computer_asserts (
	input logic clock_50,
	input logic arst_n,
	input logic req,
	input logic ack,
	input logic wr_go
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failure tally, read by the testbench at the end
	int fail_cnt = 0;

	// Ack held low for two cycles after reset release
	a_ack_after_reset: assert property (@(posedge clock_50) $rose(arst_n) |-> !ack ##1 !ack)
		else begin
			$error("ack high right after reset release");
			fail_cnt++;
		end

	// Ack only answers a live request
	a_ack_rise: assert property (@(posedge clock_50) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else begin
			$error("ack rose without req");
			fail_cnt++;
		end

	// Req must be seen low for a cycle first
	a_ack_fall: assert property (@(posedge clock_50) disable iff (!arst_n)
		$fell(ack) |-> $past(!req) && $past(!req, 2))
		else begin
			$error("ack fell before req was low");
			fail_cnt++;
		end

	// Exactly one strobe cycle per write, under a live request
	a_strobe_width: assert property (@(posedge clock_50) disable iff (!arst_n)
		wr_go |-> req ##1 !wr_go)
		else begin
			$error("write strobe longer than one cycle or without req");
			fail_cnt++;
		end

endmodule

bind bus_ctrl computer_asserts u_asserts (
	.clock_50 (clock_50),
	.arst_n   (arst_n),
	.req      (req),
	.ack      (ack),
	.wr_go    (wr_go)
);

//--- de1_soc_computer.sv
// DE1-SoC board top for the peripheral subsystem
// Ties the host bus to LEDs, switches, keys and HEX displays
module de1_soc_computer #(
	parameter int num_sw  = 10,
	parameter int num_key = 4,
	parameter int num_led = 10
) (
	input  logic                            clock_50,
	input  logic                            arst_n,
	// Host bus
	input  logic                            req,
	input  logic                            we,
	input  logic [computer_pkg::addr_w-1:0] addr,
	input  logic [computer_pkg::data_w-1:0] wdata,
	output logic                            ack,
	output logic [computer_pkg::data_w-1:0] rdata,
	// Board pins
	input  logic [num_sw-1:0]               sw,
	input  logic [num_key-1:0]              key,
	output logic [num_led-1:0]              ledr,
	output logic [computer_pkg::seg_w-1:0]  hex0,
	output logic [computer_pkg::seg_w-1:0]  hex1,
	output logic [computer_pkg::seg_w-1:0]  hex2,
	output logic [computer_pkg::seg_w-1:0]  hex3,
	output logic [computer_pkg::seg_w-1:0]  hex4,
	output logic [computer_pkg::seg_w-1:0]  hex5
);
	import computer_pkg::*;

	logic [num_key-1:0]         key_act;
	logic [num_sw-1:0]          sw_level;
	logic [num_key-1:0]         key_level;
	logic [num_key-1:0]         edge_bits;
	logic [data_w-1:0]          hex3_0_word;
	logic [data_w/2-1:0]        hex5_4_word;
	logic                       edge_clr;
	logic                       hex3_0_wr;
	logic                       hex5_4_wr;
	logic [data_w-1:0]          wr_data;
	logic                       hex_mode;
	logic [5:0][seg_w-1:0]      hex_seg;

	// Keys pull low when pressed
	assign key_act = ~key;

	bus_ctrl #(
		.num_sw  (num_sw),
		.num_key (num_key),
		.num_led (num_led)
	) u_bus_ctrl (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.req         (req),
		.we          (we),
		.addr        (addr),
		.wdata       (wdata),
		.ack         (ack),
		.rdata       (rdata),
		.sw_level    (sw_level),
		.key_level   (key_level),
		.edge_bits   (edge_bits),
		.hex3_0_word (hex3_0_word),
		.hex5_4_word (hex5_4_word),
		.edge_clr    (edge_clr),
		.hex3_0_wr   (hex3_0_wr),
		.hex5_4_wr   (hex5_4_wr),
		.wr_data     (wr_data),
		.hex_mode    (hex_mode),
		.led         (ledr)
	);

	input_capture #(
		.num_sw  (num_sw),
		.num_key (num_key)
	) u_input_capture (
		.clock_50  (clock_50),
		.arst_n    (arst_n),
		.sw        (sw),
		.key       (key_act),
		.edge_clr  (edge_clr),
		.wr_data   (wr_data),
		.sw_level  (sw_level),
		.key_level (key_level),
		.edge_bits (edge_bits)
	);

	hex_display u_hex_display (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.hex3_0_wr   (hex3_0_wr),
		.hex5_4_wr   (hex5_4_wr),
		.wr_data     (wr_data),
		.hex_mode    (hex_mode),
		.hex3_0_word (hex3_0_word),
		.hex5_4_word (hex5_4_word),
		.hex_seg     (hex_seg)
	);

	// Segment pins are active low
	assign hex0 = ~hex_seg[0];
	assign hex1 = ~hex_seg[1];
	assign hex2 = ~hex_seg[2];
	assign hex3 = ~hex_seg[3];
	assign hex4 = ~hex_seg[4];
	assign hex5 = ~hex_seg[5];

endmodule

//--- hex_display.sv
// Seven-segment display registers for HEX5..HEX0
// Decodes each display byte as raw segments or as a hex digit
module hex_display (
	input  logic                                  clock_50,
	input  logic                                  arst_n,
	// Write strobes from the bus
	input  logic                                  hex3_0_wr,
	input  logic                                  hex5_4_wr,
	input  logic [computer_pkg::data_w-1:0]       wr_data,
	input  logic                                  hex_mode,
	// Read ports
	output logic [computer_pkg::data_w-1:0]       hex3_0_word,
	output logic [computer_pkg::data_w/2-1:0]     hex5_4_word,
	// Active-high segments, display 0 in the low slot
	output logic [5:0][computer_pkg::seg_w-1:0]   hex_seg
);
	import computer_pkg::*;

	// Hex font, segments a..g in bits 0..6, index 0 at the right
	localparam logic [15:0][seg_w-1:0] hex_font = {
		7'h71, 7'h79, 7'h5e, 7'h39,
		7'h7c, 7'h77, 7'h6f, 7'h7f,
		7'h07, 7'h7d, 7'h6d, 7'h66,
		7'h4f, 7'h5b, 7'h06, 7'h3f
	};

	hex_word_t             lo_q;
	logic [data_w/2-1:0]   hi_q;
	hex_word_t             hi_view;

	// One display out of a word, in either view
	function automatic logic [seg_w-1:0] seg_of(
		input hex_word_t w,
		input int unsigned idx,
		input logic dig_mode
	);
		logic [seg_w-1:0] seg;
		if (!dig_mode) begin
			seg = w.raw[idx][seg_w-1:0];
		end else if (w.dig[idx][1][3]) begin
			// Blank bit set
			seg = '0;
		end else begin
			seg = hex_font[w.dig[idx][0]];
		end
		return seg;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Display registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			lo_q <= '0;
			hi_q <= '0;
		end else begin
			if (hex3_0_wr) begin
				lo_q <= wr_data;
			end
			if (hex5_4_wr) begin
				hi_q <= wr_data[data_w/2-1:0];
			end
		end
	end

	assign hex3_0_word = lo_q;
	assign hex5_4_word = hi_q;

	// HEX5..HEX4 seen as a full word, upper bytes unused
	assign hi_view = {{(data_w/2){1'b0}}, hi_q};

	//////////////////////////////////////////////////////////////////////
	// Segment decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hex_seg[i] = seg_of(lo_q, i, hex_mode);
		end
		for (int i = 0; i < 2; i++) begin
			hex_seg[i+4] = seg_of(hi_view, i, hex_mode);
		end
	end

endmodule

//--- input_capture.sv
// Switch and pushbutton input stage
// Two-flop synchronizers and sticky rising-edge capture for the keys
module input_capture #(
	parameter int num_sw  = 10,
	parameter int num_key = 4
) (
	input  logic                            clock_50,
	input  logic                            arst_n,
	// Pins, keys already active high
	input  logic [num_sw-1:0]               sw,
	input  logic [num_key-1:0]              key,
	// Edge clear from the bus
	input  logic                            edge_clr,
	input  logic [computer_pkg::data_w-1:0] wr_data,
	// Read ports
	output logic [num_sw-1:0]               sw_level,
	output logic [num_key-1:0]              key_level,
	output logic [num_key-1:0]              edge_bits
);

	localparam int in_w = num_sw + num_key;

	logic [in_w-1:0]    sync_meta;
	logic [in_w-1:0]    sync_q;
	logic [num_key-1:0] key_prev;
	logic [num_key-1:0] key_rise;
	logic [num_key-1:0] clr_mask;
	logic [num_key-1:0] edge_q;

	//////////////////////////////////////////////////////////////////////
	// Synchronizers
	//////////////////////////////////////////////////////////////////////

	// Switches and keys share one two-stage chain
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync_meta <= '0;
			sync_q    <= '0;
		end else begin
			sync_meta <= {sw, key};
			sync_q    <= sync_meta;
		end
	end

	assign {sw_level, key_level} = sync_q;

	//////////////////////////////////////////////////////////////////////
	// Edge capture
	//////////////////////////////////////////////////////////////////////

	// Previous synchronized key level
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			key_prev <= '0;
		end else begin
			key_prev <= key_level;
		end
	end

	assign key_rise = key_level & ~key_prev;

	// Only the 1-bits of the write clear
	assign clr_mask = edge_clr ? wr_data[num_key-1:0] : '0;

	// A new edge wins over a clear in the same cycle
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			edge_q <= '0;
		end else begin
			edge_q <= (edge_q & ~clr_mask) | key_rise;
		end
	end

	assign edge_bits = edge_q;

endmodule

//--- bus_ctrl.sv
// Host bus slave for the peripheral subsystem
// Four-phase req/ack handshake, register decode, LED and mode registers
module bus_ctrl #(
	parameter int num_sw  = 10,
	parameter int num_key = 4,
	parameter int num_led = 10
) (
	input  logic                                clock_50,
	input  logic                                arst_n,
	// Host bus
	input  logic                                req,
	input  logic                                we,
	input  logic [computer_pkg::addr_w-1:0]     addr,
	input  logic [computer_pkg::data_w-1:0]     wdata,
	output logic                                ack,
	output logic [computer_pkg::data_w-1:0]     rdata,
	// Read ports from the peripherals
	input  logic [num_sw-1:0]                   sw_level,
	input  logic [num_key-1:0]                  key_level,
	input  logic [num_key-1:0]                  edge_bits,
	input  logic [computer_pkg::data_w-1:0]     hex3_0_word,
	input  logic [computer_pkg::data_w/2-1:0]   hex5_4_word,
	// Write strobes and data
	output logic                                edge_clr,
	output logic                                hex3_0_wr,
	output logic                                hex5_4_wr,
	output logic [computer_pkg::data_w-1:0]     wr_data,
	// Local registers
	output logic                                hex_mode,
	output logic [num_led-1:0]                  led
);
	import computer_pkg::*;

	// Handshake states
	localparam logic st_idle  = 1'b0;
	localparam logic st_acked = 1'b1;

	logic               state;
	logic               req_q;
	logic               go;
	logic               wr_go;
	logic [num_led-1:0] led_q;
	logic               mode_q;
	logic [data_w-1:0]  rd_mux;

	//////////////////////////////////////////////////////////////////////
	// Request sampling and strobes
	//////////////////////////////////////////////////////////////////////

	// Registered req, one cycle behind the pin
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			req_q <= 1'b0;
		end else begin
			req_q <= req;
		end
	end

	// Live only in the cycle before ack rises
	assign go    = (state == st_idle) && req_q;
	assign wr_go = go && we;

	// One-cycle strobes, addr and we held stable by the host
	assign edge_clr  = wr_go && (addr == reg_edge);
	assign hex3_0_wr = wr_go && (addr == reg_hex3_0);
	assign hex5_4_wr = wr_go && (addr == reg_hex5_4);
	assign wr_data   = wdata;

	assign ack      = (state == st_acked);
	assign led      = led_q;
	assign hex_mode = mode_q;

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_mux = '0;
		case (addr)
			reg_led:      rd_mux[num_led-1:0] = led_q;
			reg_sw:       rd_mux[num_sw-1:0]  = sw_level;
			reg_key:      rd_mux[num_key-1:0] = key_level;
			reg_edge:     rd_mux[num_key-1:0] = edge_bits;
			reg_hex3_0:   rd_mux              = hex3_0_word;
			reg_hex5_4:   rd_mux[data_w/2-1:0] = hex5_4_word;
			reg_hex_mode: rd_mux[0]           = mode_q;
			// Unmapped reads return zero
			default:      rd_mux              = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			rdata <= '0;
		end else begin
			case (state)
				st_idle: begin
					// Ack and capture read data together
					if (req_q) begin
						state <= st_acked;
						rdata <= rd_mux;
					end
				end
				default: begin
					// Hold until the host drops req
					if (!req_q) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// LED and mode registers, written on the ack edge
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			led_q  <= '0;
			mode_q <= 1'b0;
		end else begin
			if (wr_go && (addr == reg_led)) begin
				led_q <= wdata[num_led-1:0];
			end
			if (wr_go && (addr == reg_hex_mode)) begin
				mode_q <= wdata[0];
			end
		end
	end

endmodule

//--- computer_pkg.sv
// Shared definitions for the DE1-SoC peripheral subsystem
// Bus widths, register map and the HEX display word
package computer_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	localparam int addr_w = 3;
	localparam int data_w = 32;

	// Segments a..g per display
	localparam int seg_w = 7;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	localparam logic [addr_w-1:0] reg_led      = 3'd0;
	localparam logic [addr_w-1:0] reg_sw       = 3'd1;
	localparam logic [addr_w-1:0] reg_key      = 3'd2;
	// Write 1s to clear captured edges
	localparam logic [addr_w-1:0] reg_edge     = 3'd3;
	localparam logic [addr_w-1:0] reg_hex3_0   = 3'd4;
	// Low half only, upper half reads zero
	localparam logic [addr_w-1:0] reg_hex5_4   = 3'd5;
	// Bit 0 selects raw (0) or digit (1)
	localparam logic [addr_w-1:0] reg_hex_mode = 3'd6;

	//////////////////////////////////////////////////////////////////////
	// HEX display word
	//////////////////////////////////////////////////////////////////////

	// One byte per display in both views
	// raw: low 7 bits are segments a..g
	// dig: nibble 1 bit 3 is blank, nibble 0 is the hex digit
	typedef union packed {
		logic [3:0][7:0]      raw;
		logic [3:0][1:0][3:0] dig;
	} hex_word_t;

endpackage
